//--- run.sh
#!/bin/sh
# Build the ALU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module aluTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/ValuTb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^TEST OK$'; then
  exit 0
fi
exit 1

//--- src.f
verilog/aluPkg.sv
verilog/shifter.sv
verilog/satAdder.sv
verilog/aluCore.sv
verilog/aluRegs.sv
verilog/aluTop.sv
tb/aluChecker.sv
tb/aluTb.sv

//--- tb/aluChecker.sv
// Watches the AXI4-Lite port, models the register file and the ALU from the opcode rules
// Expects at most one outstanding write and one outstanding read at a time
`timescale 1ns/1ps
`default_nettype none

module aluChecker (
  input  wire logic              clk,
  input  wire logic              arstN,
  input  wire aluPkg::axiLiteReq axiReq,
  input  wire aluPkg::axiLiteRsp axiRsp,
  output int                     errCount
);

  logic [aluPkg::dataW-1:0]    opA;
  logic [aluPkg::dataW-1:0]    opB;
  aluPkg::aluResult            expResult;
  logic [aluPkg::axiDataW-1:0] expRdata;
  logic [aluPkg::addrW-1:0]    rdAddr;
  int                          pendingResp;
  logic                        expWrReady;

  // Write ready pair only with both valids up and no response waiting
  assign expWrReady = axiReq.awvalid & axiReq.wvalid & ~axiRsp.bvalid;

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic int clampTo(input int s, input int lo, input int hi);
    if (s > hi) return hi;
    if (s < lo) return lo;
    return s;
  endfunction

  function automatic aluPkg::aluResult model(input aluPkg::aluOp op,
                                             input logic [15:0] a, input logic [15:0] b);
    aluPkg::aluResult r;
    int               s;
    int               lane;
    int               i;
    logic [3:0]       sh;
    sh = b[3:0];
    r  = '0;
    case (op)
      aluPkg::opAdd, aluPkg::opSub: begin
        // True signed result, then clamp to the 16-bit range
        if (op == aluPkg::opAdd) s = int'($signed(a)) + int'($signed(b));
        else s = int'($signed(a)) - int'($signed(b));
        r.value   = 16'(clampTo(s, -32768, 32767));
        r.flags.v = (s > 32767) || (s < -32768);
      end
      aluPkg::opPaddsb: begin
        // Four signed nibbles clamped one by one
        for (i = 0; i < 4; i++) begin
          lane = int'($signed(a[i*4 +: 4])) + int'($signed(b[i*4 +: 4]));
          r.value[i*4 +: 4] = 4'(clampTo(lane, -8, 7));
          if (lane > 7 || lane < -8) r.flags.v = 1'b1;
        end
      end
      aluPkg::opXor: r.value = a ^ b;
      aluPkg::opSll: r.value = a << sh;
      aluPkg::opSra: r.value = 16'(int'($signed(a)) >>> sh);
      aluPkg::opRor: r.value = (sh == 4'd0) ? a : ((a >> sh) | (a << (16 - sh)));
      default:       r = '0;
    endcase
    r.flags.z = (r.value == 16'h0);
    r.flags.n = r.value[15];
    return r;
  endfunction

  //////////////////////////////
  // Bus monitor
  //////////////////////////////
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      opA         <= '0;
      opB         <= '0;
      expResult   <= '0;
      expRdata    <= '0;
      rdAddr      <= '0;
      pendingResp = 0;
      errCount    = 0;
    end else begin
      // Ready signals follow the handshake rules every cycle
      if (axiRsp.awready !== expWrReady) begin
        $display("** Error: awready is 0x%h, expected 0x%h", axiRsp.awready, expWrReady);
        errCount++;
      end
      if (axiRsp.wready !== expWrReady) begin
        $display("** Error: wready is 0x%h, expected 0x%h", axiRsp.wready, expWrReady);
        errCount++;
      end
      if (axiRsp.arready !== !axiRsp.rvalid) begin
        $display("** Error: arready is 0x%h, expected 0x%h", axiRsp.arready, !axiRsp.rvalid);
        errCount++;
      end
      // Accepted write
      if (axiReq.awvalid && axiReq.wvalid && axiRsp.awready && axiRsp.wready) begin
        if (pendingResp != 0) begin
          $display("Write accepted while a write response was still pending");
          errCount++;
        end
        pendingResp = pendingResp + 1;
        case (axiReq.awaddr)
          aluPkg::regOpA: opA <= axiReq.wdata[15:0];
          aluPkg::regOpB: opB <= axiReq.wdata[15:0];
          aluPkg::regCtrl: begin
            // No-op leaves the previous result in place
            if (axiReq.wdata[2:0] != aluPkg::opNop)
              expResult <= model(aluPkg::aluOp'(axiReq.wdata[2:0]), opA, opB);
          end
          default: ;
        endcase
      end
      // Write response taken by the host
      if (axiRsp.bvalid && axiReq.bready) begin
        if (pendingResp == 0) begin
          $display("Write response seen with no write pending");
          errCount++;
        end else begin
          pendingResp = pendingResp - 1;
        end
      end
      // Expected data snapshot when the read address is taken
      if (axiReq.arvalid && axiRsp.arready) begin
        rdAddr <= axiReq.araddr;
        case (axiReq.araddr)
          aluPkg::regOpA:    expRdata <= {16'h0, opA};
          aluPkg::regOpB:    expRdata <= {16'h0, opB};
          aluPkg::regResult: expRdata <= {13'h0, expResult};
          default:           expRdata <= '0;
        endcase
      end
      // Read data taken by the host
      if (axiRsp.rvalid && axiReq.rready) begin
        if (axiRsp.rdata !== expRdata) begin
          $display("** Error: rdata at address 0x%h is 0x%h, expected 0x%h",
                   rdAddr, axiRsp.rdata, expRdata);
          errCount++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/aluTb.sv
// Testbench for the AXI4-Lite ALU; checking lives in aluChecker
// Each row writes A, B and the opcode, then reads A, B and the result back
`timescale 1ns/1ps
`default_nettype none

module aluTb;

  localparam int timeoutCycles = 50;
  localparam int nRandom       = 20;

  // Opcode, operands, and bready hold cycles on the control write
  typedef struct packed {
    aluPkg::aluOp op;
    logic [15:0]  a;
    logic [15:0]  b;
    logic [3:0]   holdB;
  } stimRow;

  logic              clk;
  logic              arstN;
  aluPkg::axiLiteReq axiReq;
  aluPkg::axiLiteRsp axiRsp;
  int                errCount;
  int                timeoutCount;
  integer            seed;
  stimRow            rows[$];

  aluTop DUT (
    .clk    (clk),
    .arstN  (arstN),
    .axiReq (axiReq),
    .axiRsp (axiRsp)
  );

  aluChecker uChecker (
    .clk      (clk),
    .arstN    (arstN),
    .axiReq   (axiReq),
    .axiRsp   (axiRsp),
    .errCount (errCount)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Host tasks
  //////////////////////////////
  function automatic void addRow(input aluPkg::aluOp op, input logic [15:0] a,
                                 input logic [15:0] b, input int holdB);
    stimRow row;
    row.op    = op;
    row.a     = a;
    row.b     = b;
    row.holdB = 4'(holdB);
    rows.push_back(row);
  endfunction

  // Address and data together; bready held low for holdB cycles
  task automatic writeReg(input logic [3:0] addr, input logic [31:0] data, input int holdB);
    int waitCnt;
    @(negedge clk);
    axiReq.awvalid = 1'b1;
    axiReq.awaddr  = addr;
    axiReq.wvalid  = 1'b1;
    axiReq.wdata   = data;
    axiReq.bready  = (holdB == 0);
    waitCnt = 0;
    while (!axiRsp.bvalid && waitCnt < timeoutCycles) begin
      @(negedge clk);
      waitCnt++;
    end
    if (!axiRsp.bvalid) begin
      $display("Timeout waiting for the write response to address 0x%h", addr);
      timeoutCount++;
    end
    axiReq.awvalid = 1'b0;
    axiReq.wvalid  = 1'b0;
    // Back-pressure on the response channel
    repeat (holdB) @(negedge clk);
    axiReq.bready = 1'b1;
    waitCnt = 0;
    while (axiRsp.bvalid && waitCnt < timeoutCycles) begin
      @(negedge clk);
      waitCnt++;
    end
    if (axiRsp.bvalid) begin
      $display("Timeout waiting for bvalid to drop at address 0x%h", addr);
      timeoutCount++;
    end
    axiReq.bready = 1'b0;
  endtask

  // Data is compared by the checker when rvalid meets rready
  task automatic readReg(input logic [3:0] addr);
    int waitCnt;
    @(negedge clk);
    axiReq.arvalid = 1'b1;
    axiReq.araddr  = addr;
    axiReq.rready  = 1'b1;
    waitCnt = 0;
    while (!axiRsp.rvalid && waitCnt < timeoutCycles) begin
      @(negedge clk);
      waitCnt++;
    end
    if (!axiRsp.rvalid) begin
      $display("Timeout waiting for read data from address 0x%h", addr);
      timeoutCount++;
    end
    axiReq.arvalid = 1'b0;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    stimRow row;
    int     i;
    axiReq       = '0;
    arstN        = 1'b0;
    timeoutCount = 0;
    seed         = 32'h3570;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    // Add and subtract both plain and clamped
    addRow(aluPkg::opAdd, 16'h1234, 16'h0101, 0);
    addRow(aluPkg::opAdd, 16'h7FFF, 16'h0001, 0);
    addRow(aluPkg::opAdd, 16'h8000, 16'h8000, 0);
    addRow(aluPkg::opSub, 16'h0005, 16'h0003, 0);
    addRow(aluPkg::opSub, 16'h8000, 16'h0001, 0);
    addRow(aluPkg::opSub, 16'h1234, 16'h1234, 0);
    // Nibble lanes with some of them saturating
    addRow(aluPkg::opPaddsb, 16'h1234, 16'h1111, 0);
    addRow(aluPkg::opPaddsb, 16'h7788, 16'h1188, 0);
    addRow(aluPkg::opPaddsb, 16'h0F0F, 16'h0101, 0);
    // Shifts by 0, 1, 4 and 15
    addRow(aluPkg::opSll, 16'h00F1, 16'h0000, 0);
    addRow(aluPkg::opSll, 16'h00F1, 16'h0001, 0);
    addRow(aluPkg::opSll, 16'h00F1, 16'h0004, 0);
    addRow(aluPkg::opSll, 16'h00F1, 16'h000F, 0);
    addRow(aluPkg::opSra, 16'h8010, 16'h0000, 0);
    addRow(aluPkg::opSra, 16'h8010, 16'h0001, 0);
    addRow(aluPkg::opSra, 16'h8010, 16'h0004, 0);
    addRow(aluPkg::opSra, 16'h8010, 16'h000F, 0);
    addRow(aluPkg::opSra, 16'h4000, 16'h0004, 0);
    addRow(aluPkg::opRor, 16'h1234, 16'h0000, 0);
    addRow(aluPkg::opRor, 16'h1234, 16'h0001, 0);
    addRow(aluPkg::opRor, 16'h1234, 16'h0004, 0);
    addRow(aluPkg::opRor, 16'h1234, 16'h000F, 0);
    // XOR with Z and N, then a no-op that keeps the result
    addRow(aluPkg::opXor, 16'hA5A5, 16'hA5A5, 0);
    addRow(aluPkg::opXor, 16'hFFFF, 16'h00FF, 0);
    addRow(aluPkg::opNop, 16'h1111, 16'h2222, 0);
    // Response held back on the control write
    addRow(aluPkg::opAdd, 16'h0100, 16'h0200, 6);

    for (i = 0; i < nRandom; i++) begin
      row.op    = aluPkg::aluOp'(3'($random(seed)));
      row.a     = 16'($random(seed));
      row.b     = 16'($random(seed));
      row.holdB = 4'h0;
      rows.push_back(row);
    end

    for (i = 0; i < rows.size(); i++) begin
      writeReg(aluPkg::regOpA, {16'h0, rows[i].a}, 0);
      writeReg(aluPkg::regOpB, {16'h0, rows[i].b}, 0);
      writeReg(aluPkg::regCtrl, {29'h0, rows[i].op}, int'(rows[i].holdB));
      readReg(aluPkg::regOpA);
      readReg(aluPkg::regOpB);
      readReg(aluPkg::regResult);
      if (timeoutCount != 0) break;
    end

    // Unmapped offset and the write-only control register read as zero
    if (timeoutCount == 0) begin
      readReg(4'h2);
      readReg(aluPkg::regCtrl);
    end

    // Let the last read response reach the checker
    repeat (3) @(negedge clk);
    $display("Errors: %0d, timeouts: %0d", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/aluCore.sv
// Execution core, result register loads one cycle after a launch pulse
// opNop and idle cycles leave the previous result in place
`timescale 1ns/1ps
`default_nettype none

module aluCore (
  input  wire logic          clk,
  input  wire logic          arstN,
  input  wire aluPkg::aluReq req,
  output aluPkg::aluResult   result
);

  aluPkg::shiftMode         mode;
  logic                     sub;
  logic                     lanes;
  logic                     isArith;
  logic [aluPkg::dataW-1:0] shiftOut;
  logic [aluPkg::dataW-1:0] sum;
  logic                     ovf;
  aluPkg::aluResult         nextResult;

  //////////////////////////////
  // Opcode decode
  //////////////////////////////
  always_comb begin
    case (req.op)
      aluPkg::opSll: mode = aluPkg::modeSll;
      aluPkg::opSra: mode = aluPkg::modeSra;
      aluPkg::opRor: mode = aluPkg::modeRor;
      default:       mode = aluPkg::modeNone;
    endcase
  end

  assign sub     = (req.op == aluPkg::opSub);
  assign lanes   = (req.op == aluPkg::opPaddsb);
  // Only these report overflow
  assign isArith = (req.op == aluPkg::opAdd) | sub | lanes;

  // Shift amount comes from the low bits of operand B
  shifter uShifter (
    .shiftIn  (req.a),
    .shiftVal (req.b[aluPkg::shiftW-1:0]),
    .mode     (mode),
    .shiftOut (shiftOut)
  );

  satAdder uAdder (
    .a     (req.a),
    .b     (req.b),
    .sub   (sub),
    .lanes (lanes),
    .sum   (sum),
    .ovf   (ovf)
  );

  //////////////////////////////
  // Result select and flags
  //////////////////////////////
  always_comb begin
    case (req.op)
      aluPkg::opAdd, aluPkg::opSub, aluPkg::opPaddsb: nextResult.value = sum;
      aluPkg::opXor:                                  nextResult.value = req.a ^ req.b;
      aluPkg::opSll, aluPkg::opSra, aluPkg::opRor:    nextResult.value = shiftOut;
      default:                                        nextResult.value = '0;
    endcase
    nextResult.flags.z = (nextResult.value == '0);
    nextResult.flags.v = isArith & ovf;
    nextResult.flags.n = nextResult.value[aluPkg::dataW-1];
  end

  // Load on launch; opNop holds the old value and flags
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      result <= '0;
    end else if (req.launch && (req.op != aluPkg::opNop)) begin
      result <= nextResult;
    end
  end

  // Any change of result must trace back to a launch one cycle earlier
  aResultOnLaunch: assert property (
    @(posedge clk) disable iff (!arstN)
    !$stable(result) |-> $past(req.launch)
  ) else $error("result changed without a launch");

endmodule

`default_nettype wire

//--- verilog/aluPkg.sv
// Shared widths, register map and bus types for the AXI4-Lite ALU
// Only the low 4 address bits are decoded; byte strobes are not carried
`default_nettype none

package aluPkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int dataW    = 16;
  localparam int shiftW   = 4;
  localparam int laneW    = 4;
  localparam int addrW    = 4;
  localparam int axiDataW = 32;

  // Register map, byte offsets
  localparam logic [addrW-1:0] regOpA    = 4'h0;
  localparam logic [addrW-1:0] regOpB    = 4'h4;
  localparam logic [addrW-1:0] regCtrl   = 4'h8;
  localparam logic [addrW-1:0] regResult = 4'hC;

  //////////////////////////////
  // Opcodes and shifter modes
  //////////////////////////////
  typedef enum logic [2:0] {
    opAdd    = 3'd0,
    opSub    = 3'd1,
    opXor    = 3'd2,
    opPaddsb = 3'd3,
    opSll    = 3'd4,
    opSra    = 3'd5,
    opRor    = 3'd6,
    opNop    = 3'd7
  } aluOp;

  // Same numbering as the original shifter block
  typedef enum logic [1:0] {
    modeSll  = 2'd0,
    modeSra  = 2'd1,
    modeRor  = 2'd2,
    modeNone = 2'd3
  } shiftMode;

  // Flags sit above the value, matching regResult bits [18:16]
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } aluFlags;

  typedef struct packed {
    aluFlags          flags;
    logic [dataW-1:0] value;
  } aluResult;

  // Operation request from the register block to the core
  typedef struct packed {
    aluOp             op;
    logic [dataW-1:0] a;
    logic [dataW-1:0] b;
    logic             launch;
  } aluReq;

  //////////////////////////////
  // AXI4-Lite channels
  //////////////////////////////
  typedef struct packed {
    logic                awvalid;
    logic [addrW-1:0]    awaddr;
    logic                wvalid;
    logic [axiDataW-1:0] wdata;
    logic                bready;
    logic                arvalid;
    logic [addrW-1:0]    araddr;
    logic                rready;
  } axiLiteReq;

  typedef struct packed {
    logic                awready;
    logic                wready;
    logic                bvalid;
    logic                arready;
    logic                rvalid;
    logic [axiDataW-1:0] rdata;
  } axiLiteRsp;

endpackage

`default_nettype wire

//--- verilog/aluRegs.sv
// AXI4-Lite slave with operand, control and result registers
// All responses are OKAY; unmapped reads return zero and unmapped writes drop
`timescale 1ns/1ps
`default_nettype none

module aluRegs (
  input  wire logic              clk,
  input  wire logic              arstN,
  input  wire aluPkg::axiLiteReq axiReq,
  output aluPkg::axiLiteRsp      axiRsp,
  output aluPkg::aluReq          req,
  input  wire aluPkg::aluResult  result
);

  logic                        wrAccept;
  logic                        rdAccept;
  logic                        bValidQ;
  logic                        rValidQ;
  logic [aluPkg::axiDataW-1:0] rDataQ;
  logic [aluPkg::axiDataW-1:0] rDataNext;
  logic [aluPkg::dataW-1:0]    opAQ;
  logic [aluPkg::dataW-1:0]    opBQ;
  aluPkg::aluOp                opQ;
  logic                        launchQ;

  //////////////////////////////
  // Write channel
  //////////////////////////////
  // Address and data taken together, and only with no response pending
  assign wrAccept = axiReq.awvalid & axiReq.wvalid & ~bValidQ;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      bValidQ <= 1'b0;
      launchQ <= 1'b0;
      opAQ    <= '0;
      opBQ    <= '0;
      opQ     <= aluPkg::opNop;
    end else begin
      // Launch is a single-cycle pulse
      launchQ <= 1'b0;
      if (wrAccept) begin
        bValidQ <= 1'b1;
        case (axiReq.awaddr)
          aluPkg::regOpA: opAQ <= axiReq.wdata[aluPkg::dataW-1:0];
          aluPkg::regOpB: opBQ <= axiReq.wdata[aluPkg::dataW-1:0];
          aluPkg::regCtrl: begin
            opQ     <= aluPkg::aluOp'(axiReq.wdata[2:0]);
            launchQ <= 1'b1;
          end
          default: ;
        endcase
      end else if (axiReq.bready) begin
        // Response held until the host takes it
        bValidQ <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Read channel
  //////////////////////////////
  // A pending read blocks the next address
  assign rdAccept = axiReq.arvalid & ~rValidQ;

  // Read mux, zero-extended to the bus width
  always_comb begin
    rDataNext = '0;
    case (axiReq.araddr)
      aluPkg::regOpA:    rDataNext[aluPkg::dataW-1:0] = opAQ;
      aluPkg::regOpB:    rDataNext[aluPkg::dataW-1:0] = opBQ;
      aluPkg::regResult: rDataNext[$bits(aluPkg::aluResult)-1:0] = result;
      default:           rDataNext = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rValidQ <= 1'b0;
    end else if (rdAccept) begin
      rValidQ <= 1'b1;
    end else if (axiReq.rready) begin
      rValidQ <= 1'b0;
    end
  end

  // Read data payload, stable while rvalid is up
  always_ff @(posedge clk) begin
    if (rdAccept) begin
      rDataQ <= rDataNext;
    end
  end

  // Bus outputs
  assign axiRsp.awready = wrAccept;
  assign axiRsp.wready  = wrAccept;
  assign axiRsp.bvalid  = bValidQ;
  assign axiRsp.arready = ~rValidQ;
  assign axiRsp.rvalid  = rValidQ;
  assign axiRsp.rdata   = rDataQ;

  // Request to the core
  assign req.op     = opQ;
  assign req.a      = opAQ;
  assign req.b      = opBQ;
  assign req.launch = launchQ;

  //////////////////////////////
  // Protocol checks
  //////////////////////////////
  aBvalidHold: assert property (
    @(posedge clk) disable iff (!arstN)
    axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid
  ) else $error("bvalid dropped before bready");

  aLaunchPulse: assert property (
    @(posedge clk) disable iff (!arstN)
    req.launch |=> !req.launch
  ) else $error("launch held longer than one cycle");

endmodule

`default_nettype wire

//--- verilog/aluTop.sv
// ALU top level, host access through AXI4-Lite only
// One operation per control write, no pipelining
`timescale 1ns/1ps
`default_nettype none

module aluTop (
  input  wire logic              clk,
  input  wire logic              arstN,
  input  wire aluPkg::axiLiteReq axiReq,
  output aluPkg::axiLiteRsp      axiRsp
);

  // Register block to core
  aluPkg::aluReq    req;
  // Core back to readback
  aluPkg::aluResult result;

  aluRegs uRegs (
    .clk    (clk),
    .arstN  (arstN),
    .axiReq (axiReq),
    .axiRsp (axiRsp),
    .req    (req),
    .result (result)
  );

  aluCore uCore (
    .clk    (clk),
    .arstN  (arstN),
    .req    (req),
    .result (result)
  );

endmodule

`default_nettype wire

//--- verilog/satAdder.sv
// Saturating add/subtract, either one 16-bit word or four signed 4-bit lanes
// Lane mode always adds; sub only applies to the 16-bit path
`timescale 1ns/1ps
`default_nettype none

module satAdder (
  input  wire logic [aluPkg::dataW-1:0] a,
  input  wire logic [aluPkg::dataW-1:0] b,
  input  wire logic                     sub,
  input  wire logic                     lanes,
  output logic [aluPkg::dataW-1:0]      sum,
  output logic                          ovf
);

  localparam int nLanes = aluPkg::dataW / aluPkg::laneW;

  //////////////////////////////
  // Full-width path
  //////////////////////////////
  logic [aluPkg::dataW-1:0] bEff;
  logic [aluPkg::dataW:0]   wideSum;
  logic                     wideOvf;
  logic [aluPkg::dataW-1:0] wideSat;

  // Subtract as a plus inverted b plus one
  assign bEff = sub ? ~b : b;

  // One guard bit; overflow shows as the top two bits disagreeing
  assign wideSum = {a[aluPkg::dataW-1], a} + {bEff[aluPkg::dataW-1], bEff} + {16'h0, sub};
  assign wideOvf = wideSum[aluPkg::dataW] ^ wideSum[aluPkg::dataW-1];

  // Guard bit holds the true sign, so it picks the clamp
  assign wideSat = !wideOvf ? wideSum[aluPkg::dataW-1:0] :
                   wideSum[aluPkg::dataW] ? 16'h8000 : 16'h7FFF;

  //////////////////////////////
  // Lane path
  //////////////////////////////
  logic [aluPkg::dataW-1:0] laneSum;
  logic [nLanes-1:0]        laneOvf;

  for (genvar i = 0; i < nLanes; i++) begin : gLane
    logic [aluPkg::laneW-1:0] aL;
    logic [aluPkg::laneW-1:0] bL;
    logic [aluPkg::laneW:0]   s;

    assign aL = a[i*aluPkg::laneW +: aluPkg::laneW];
    assign bL = b[i*aluPkg::laneW +: aluPkg::laneW];
    assign s  = {aL[aluPkg::laneW-1], aL} + {bL[aluPkg::laneW-1], bL};

    assign laneOvf[i] = s[aluPkg::laneW] ^ s[aluPkg::laneW-1];
    // Clamp each lane to +7 or -8 on its own
    assign laneSum[i*aluPkg::laneW +: aluPkg::laneW] =
      !laneOvf[i] ? s[aluPkg::laneW-1:0] :
      s[aluPkg::laneW] ? 4'h8 : 4'h7;
  end

  // Output select
  assign sum = lanes ? laneSum : wideSat;
  assign ovf = lanes ? |laneOvf : wideOvf;

endmodule

`default_nettype wire

//--- verilog/shifter.sv
// Combinational 16-bit shifter, amount is the low 4 bits only
// modeNone passes the input straight through
`timescale 1ns/1ps
`default_nettype none

module shifter (
  input  wire logic [aluPkg::dataW-1:0]  shiftIn,
  input  wire logic [aluPkg::shiftW-1:0] shiftVal,
  input  wire aluPkg::shiftMode          mode,
  output logic [aluPkg::dataW-1:0]       shiftOut
);

  // One result per mode
  logic [aluPkg::dataW-1:0]   sllOut;
  logic [aluPkg::dataW-1:0]   sraOut;
  logic [aluPkg::dataW-1:0]   rorOut;
  // Input doubled so a plain right shift becomes a rotate
  logic [2*aluPkg::dataW-1:0] rorWide;

  // Zero fill from the right
  assign sllOut = shiftIn << shiftVal;

  // Sign bit replicated from the left
  assign sraOut = $signed(shiftIn) >>> shiftVal;

  // Low half of the shifted pair is the rotated word
  // Amount of zero leaves the input untouched
  assign rorWide = {shiftIn, shiftIn} >> shiftVal;
  assign rorOut  = rorWide[aluPkg::dataW-1:0];

  // Mode select
  always_comb begin
    case (mode)
      aluPkg::modeSll: shiftOut = sllOut;
      aluPkg::modeSra: shiftOut = sraOut;
      aluPkg::modeRor: shiftOut = rorOut;
      default:         shiftOut = shiftIn;
    endcase
  end

endmodule

`default_nettype wire
